//--- Makefile
VERILATOR ?= verilator
TOP       ?= c_sram_ctrl_tb
FLIST     ?= c_sram_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- c_sram_ctrl.f
+incdir+rtl
rtl/c_tile_pkg.sv
rtl/c_cpu_pkg.sv
rtl/c_tile_if.sv
rtl/c_tile_writer.sv
rtl/c_tile_sram.sv
rtl/c_read_ctrl.sv
rtl/c_sram_ctrl.sv
tests/c_sram_ctrl_properties.sv
tests/c_sram_ctrl_tb.sv

//--- rtl/c_cpu_pkg.sv
package c_cpu_pkg;

  // ==================================================
  // cpu read side
  // ==================================================

  // read controller state
  // idle waits for a cpu request once the tile is done
  // wait holds the address until the memory returns the word
  typedef enum logic {
    RD_IDLE = 1'b0,
    RD_WAIT = 1'b1
  } rd_state_t;

endpackage

//--- rtl/c_read_ctrl.sv
`include "c_tile_config.svh"

module c_read_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  c_wr_if.mon                wmon,
  c_rd_if.ctrl               rd,
  input  logic               cpu_en,
  input  c_tile_pkg::row_t   cpu_row,
  input  c_tile_pkg::col_t   cpu_col,
  output c_tile_pkg::word_t  cpu_rdata,
  output logic               cpu_rvalid,
  output logic               tile_done
);
  import c_tile_pkg::*;
  import c_cpu_pkg::*;

  localparam int unsigned GAP   = `C_TILE_DRAIN_GAP;
  localparam int unsigned CNT_W = (GAP < 1) ? 1 : $clog2(GAP + 1);

  // ==================================================
  // drain detector
  // ==================================================

  // armed from start until the tile is declared done
  logic             armed_q;
  // at least one write seen since start
  logic             wrote_q;
  // write-free cycles since the last write, saturates at GAP
  logic [CNT_W-1:0] quiet_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      armed_q   <= 1'b0;
      wrote_q   <= 1'b0;
      quiet_q   <= '0;
      tile_done <= 1'b0;
    end else if (start) begin
      // a write in the start cycle already belongs to the new tile
      armed_q   <= 1'b1;
      wrote_q   <= wmon.we;
      quiet_q   <= '0;
      tile_done <= 1'b0;
    end else begin
      if (wmon.we) begin
        wrote_q <= 1'b1;
        quiet_q <= '0;
      end else if (armed_q && wrote_q && (quiet_q != CNT_W'(GAP))) begin
        quiet_q <= quiet_q + 1'b1;
      end
      // quiet long enough, tile stays done until the next start
      if (armed_q && wrote_q && !wmon.we && (quiet_q == CNT_W'(GAP))) begin
        tile_done <= 1'b1;
        armed_q   <= 1'b0;
      end
    end
  end

  // ==================================================
  // cpu read FSM
  // ==================================================

  rd_state_t state_q;
  // address held for the memory access
  row_t      row_q;
  col_t      col_q;

  // one read issued per request, en drops once the word is back
  assign rd.en  = (state_q == RD_WAIT) && !rd.rvalid;
  assign rd.row = row_q;
  assign rd.col = col_q;

  // address latch
  always_ff @(posedge clk) begin
    if ((state_q == RD_IDLE) && tile_done && cpu_en) begin
      row_q <= cpu_row;
      col_q <= cpu_col;
    end
  end

  // returned word
  always_ff @(posedge clk) begin
    if ((state_q == RD_WAIT) && rd.rvalid) begin
      cpu_rdata <= rd.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= RD_IDLE;
      cpu_rvalid <= 1'b0;
    end else begin
      // rvalid is a single cycle pulse
      cpu_rvalid <= 1'b0;
      case (state_q)
        RD_IDLE: begin
          // requests before the tile is complete are dropped
          if (tile_done && cpu_en) begin
            state_q <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (rd.rvalid) begin
            cpu_rvalid <= 1'b1;
            state_q    <= RD_IDLE;
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/c_sram_ctrl.sv
`include "c_tile_config.svh"

module c_sram_ctrl (
  input  logic                                          clk,
  input  logic                                          rst,
  // new tile result-set
  input  logic                                          start,
  // drop pending captures
  input  logic                                          flush,
  // systolic array results
  input  logic [`C_TILE_M*`C_TILE_N*`C_TILE_DATA_W-1:0] c_out_flat,
  input  logic [`C_TILE_M*`C_TILE_N-1:0]                c_valid_flat,
  // cpu read side
  input  logic                                          cpu_en,
  input  c_tile_pkg::row_t                              cpu_row,
  input  c_tile_pkg::col_t                              cpu_col,
  output c_tile_pkg::word_t                             cpu_rdata,
  output logic                                          cpu_rvalid,
  // tile fully drained into the SRAM
  output logic                                          tile_done
);

  // ==================================================
  // internal buses
  // ==================================================

  // writer to SRAM port B, also watched by the drain detector
  c_wr_if wr_bus ();

  // read controller to SRAM port A
  c_rd_if rd_bus ();

  // ==================================================
  // producer
  // ==================================================

  c_tile_writer u_wr (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .c_out_flat   (c_out_flat),
    .c_valid_flat (c_valid_flat),
    .wr           (wr_bus.writer)
  );

  // ==================================================
  // tile buffer
  // ==================================================

  c_tile_sram u_mem (
    .clk (clk),
    .rst (rst),
    .wr  (wr_bus.mem),
    .rd  (rd_bus.mem)
  );

  // ==================================================
  // consumer
  // ==================================================

  c_read_ctrl u_rd (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .wmon       (wr_bus.mon),
    .rd         (rd_bus.ctrl),
    .cpu_en     (cpu_en),
    .cpu_row    (cpu_row),
    .cpu_col    (cpu_col),
    .cpu_rdata  (cpu_rdata),
    .cpu_rvalid (cpu_rvalid),
    .tile_done  (tile_done)
  );

endmodule

//--- rtl/c_tile_config.svh
`ifndef C_TILE_CONFIG_SVH
`define C_TILE_CONFIG_SVH

// ==================================================
// tile geometry
// ==================================================

// rows of the result matrix C
`define C_TILE_M 8

// columns of the result matrix C
`define C_TILE_N 8

// bits per result word
`define C_TILE_DATA_W 32

// ==================================================
// drain detection
// ==================================================

// quiet cycles after the last SRAM write before the tile is complete
`define C_TILE_DRAIN_GAP 8

`endif

//--- rtl/c_tile_if.sv
// ==================================================
// write port, tile writer into the SRAM
// ==================================================
interface c_wr_if;
  import c_tile_pkg::*;

  // one full word write per cycle when high
  logic  we;
  row_t  wrow;
  col_t  wcol;
  word_t wdata;

  // producer side
  modport writer (
    output we,
    output wrow,
    output wcol,
    output wdata
  );

  // memory side
  modport mem (
    input we,
    input wrow,
    input wcol,
    input wdata
  );

  // drain detector only needs to see write activity
  modport mon (
    input we
  );
endinterface

// ==================================================
// read port, controller against the SRAM
// ==================================================
interface c_rd_if;
  import c_tile_pkg::*;

  // request toward memory
  logic  en;
  row_t  row;
  col_t  col;
  // response, one cycle after en
  word_t rdata;
  logic  rvalid;

  modport ctrl (output en, output row, output col, input rdata, input rvalid);
  modport mem  (input en, input row, input col, output rdata, output rvalid);
endinterface

//--- rtl/c_tile_pkg.sv
`include "c_tile_config.svh"

package c_tile_pkg;

  // ==================================================
  // index widths, never narrower than one bit
  // ==================================================

  localparam int unsigned ROW_W  = (`C_TILE_M <= 1) ? 1 : $clog2(`C_TILE_M);
  localparam int unsigned COL_W  = (`C_TILE_N <= 1) ? 1 : $clog2(`C_TILE_N);
  localparam int unsigned ELEM_W =
    (`C_TILE_M * `C_TILE_N <= 1) ? 1 : $clog2(`C_TILE_M * `C_TILE_N);

  // ==================================================
  // tile types
  // ==================================================

  // row of C
  typedef logic [ROW_W-1:0] row_t;

  // column of C
  typedef logic [COL_W-1:0] col_t;

  // one result word
  typedef logic [`C_TILE_DATA_W-1:0] word_t;

  // flat element index, row * N + col
  typedef logic [ELEM_W-1:0] elem_idx_t;

endpackage

//--- rtl/c_tile_sram.sv
`include "c_tile_config.svh"

module c_tile_sram (
  input  logic clk,
  input  logic rst,
  c_wr_if.mem  wr,
  c_rd_if.mem  rd
);
  import c_tile_pkg::*;

  // ==================================================
  // storage
  // ==================================================

  // one word per element of C, row major
  word_t mem_q [`C_TILE_M][`C_TILE_N];

  // port B, write from the tile writer
  // full word only, takes effect on the edge where we is high
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem_q[wr.wrow][wr.wcol] <= wr.wdata;
    end
  end

  // ==================================================
  // read port
  // ==================================================

  // port A, registered read data
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd.rdata <= mem_q[rd.row][rd.col];
    end
  end

  // rvalid follows en by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rd.rvalid <= 1'b0;
    end else begin
      rd.rvalid <= rd.en;
    end
  end

endmodule

//--- rtl/c_tile_writer.sv
`include "c_tile_config.svh"

module c_tile_writer (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          flush,
  input  logic [`C_TILE_M*`C_TILE_N*`C_TILE_DATA_W-1:0] c_out_flat,
  input  logic [`C_TILE_M*`C_TILE_N-1:0]                c_valid_flat,
  c_wr_if.writer                                        wr
);
  import c_tile_pkg::*;

  localparam int unsigned ELEMS = `C_TILE_M * `C_TILE_N;

  // ==================================================
  // capture
  // ==================================================

  // X or Z on a flag never counts as a valid element
  logic [ELEMS-1:0] valid_clean;

  // latched word per element
  word_t            lat_q [ELEMS];
  // element captured and not yet written
  logic [ELEMS-1:0] pend_q;
  logic [ELEMS-1:0] pend_next;

  // lowest pending element
  elem_idx_t        pick;
  logic             pend_any;

  always_comb begin
    for (int i = 0; i < ELEMS; i++) begin
      valid_clean[i] = (c_valid_flat[i] === 1'b1);
    end
  end

  // payload latch, a repeat valid just overwrites the word
  always_ff @(posedge clk) begin
    for (int i = 0; i < ELEMS; i++) begin
      if (valid_clean[i]) begin
        lat_q[i] <= c_out_flat[i*`C_TILE_DATA_W +: `C_TILE_DATA_W];
      end
    end
  end

  // ==================================================
  // priority pick and pending update
  // ==================================================

  // scan down so the lowest set bit wins
  always_comb begin
    pick = '0;
    for (int i = ELEMS - 1; i >= 0; i--) begin
      if (pend_q[i]) begin
        pick = elem_idx_t'(i);
      end
    end
  end

  assign pend_any = |pend_q;

  always_comb begin
    pend_next = pend_q;
    // issued element drops out of the backlog
    if (pend_any) begin
      pend_next[pick] = 1'b0;
    end
    // flush throws away everything still waiting
    if (flush) begin
      pend_next = '0;
    end
    // new captures land after the clear, so a fresh valid is never lost
    pend_next = pend_next | valid_clean;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_next;
    end
  end

  // ==================================================
  // write port
  // ==================================================

  // no write goes out in a flush cycle
  assign wr.we    = pend_any && !flush;
  assign wr.wrow  = row_t'(int'(pick) / `C_TILE_N);
  assign wr.wcol  = col_t'(int'(pick) % `C_TILE_N);
  assign wr.wdata = lat_q[pick];

endmodule

//--- tests/c_sram_ctrl_properties.sv
module c_sram_ctrl_properties (
  input logic clk,
  input logic rst,
  input logic start,
  input logic cpu_en,
  input logic cpu_rvalid,
  input logic tile_done
);

  // ==================================================
  // read request tracking from the ports
  // ==================================================

  // cycles until the read FSM takes a new request
  logic [1:0] busy_q;
  // request accepted on this edge
  logic       accept;

  assign accept = !rst && tile_done && cpu_en && (busy_q == 2'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 2'd0;
    end else if (accept) begin
      busy_q <= 2'd2;
    end else if (busy_q != 2'd0) begin
      busy_q <= busy_q - 2'd1;
    end
  end

  // ==================================================
  // properties
  // ==================================================

  rvalid_single: assert property (@(posedge clk) disable iff (rst) cpu_rvalid |=> !cpu_rvalid)
    else $error("cpu_rvalid high on two consecutive cycles");

  // rvalid is registered on the second edge after acceptance
  // so it is first seen high when sampled on the third edge
  rvalid_latency: assert property (@(posedge clk) disable iff (rst)
    accept |=> !cpu_rvalid ##1 !cpu_rvalid ##1 cpu_rvalid)
    else $error("cpu_rvalid not exactly two cycles after an accepted read");

  // done only drops through a start
  done_fall: assert property (@(posedge clk) disable iff (rst) $fell(tile_done) |-> $past(start))
    else $error("tile_done fell without a start");

  done_reset: assert property (@(posedge clk) rst |=> !tile_done)
    else $error("tile_done high after reset");

endmodule

bind c_sram_ctrl c_sram_ctrl_properties u_props (
  .clk        (clk),
  .rst        (rst),
  .start      (start),
  .cpu_en     (cpu_en),
  .cpu_rvalid (cpu_rvalid),
  .tile_done  (tile_done)
);

//--- tests/c_sram_ctrl_tb.sv
`include "c_tile_config.svh"

module c_sram_ctrl_tb;
  import c_tile_pkg::*;

  localparam int ELEMS      = `C_TILE_M * `C_TILE_N;
  localparam int W          = `C_TILE_DATA_W;
  localparam int GAP        = `C_TILE_DRAIN_GAP;
  localparam int DONE_LIMIT = 4 * ELEMS + 4 * GAP + 50;
  localparam int READ_LIMIT = 20;

  logic               clk;
  logic               rst;
  logic               start;
  logic               flush;
  logic [ELEMS*W-1:0] c_out_flat;
  logic [ELEMS-1:0]   c_valid_flat;
  logic               cpu_en;
  row_t               cpu_row;
  col_t               cpu_col;
  word_t              cpu_rdata;
  logic               cpu_rvalid;
  logic               tile_done;

  // last word shown with a valid flag, per element
  word_t model [ELEMS];
  int    errors;

  c_sram_ctrl i_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .flush        (flush),
    .c_out_flat   (c_out_flat),
    .c_valid_flat (c_valid_flat),
    .cpu_en       (cpu_en),
    .cpu_row      (cpu_row),
    .cpu_col      (cpu_col),
    .cpu_rdata    (cpu_rdata),
    .cpu_rvalid   (cpu_rvalid),
    .tile_done    (tile_done)
  );

  always #2 clk = ~clk;

  // ==================================================
  // stimulus and check helpers
  // ==================================================

  // all tasks start and end just after a falling edge
  task automatic pulse_start();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  // one element valid for one cycle
  task automatic present(input int e, input word_t w);
    c_valid_flat[e] = 1'b1;
    c_out_flat[e*W +: W] = w;
    model[e] = w;
    @(negedge clk);
    c_valid_flat = '0;
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (!tile_done && cnt < DONE_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!tile_done) begin
      $display("tile_done did not rise within %0d cycles", DONE_LIMIT);
      errors++;
    end
  endtask

  task automatic check_word(input int r, input int c, input word_t got);
    word_t exp;
    exp = model[r * `C_TILE_N + c];
    if (got !== exp) begin
      $display("MISMATCH cpu_rdata row %0d col %0d: expected 0x%h, got 0x%h", r, c, exp, got);
      errors++;
    end
  endtask

  // request accepted on the next rising edge, rvalid expected two edges later
  task automatic cpu_read(input int r, input int c, output word_t data);
    int cnt;
    cpu_en  = 1'b1;
    cpu_row = row_t'(r);
    cpu_col = col_t'(c);
    @(negedge clk);
    // drop the request so it is taken only once
    cpu_en = 1'b0;
    cnt = 0;
    while (!cpu_rvalid && cnt < READ_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    data = cpu_rdata;
    if (!cpu_rvalid) begin
      $display("read of row %0d col %0d got no cpu_rvalid within %0d cycles", r, c, READ_LIMIT);
      errors++;
    end else if (cnt != 2) begin
      $display("MISMATCH cpu_rvalid latency: expected 0x2, got 0x%h", cnt);
      errors++;
    end
  endtask

  task automatic read_check(input int r, input int c);
    word_t d;
    cpu_read(r, c, d);
    check_word(r, c, d);
  endtask

  task automatic read_all();
    for (int r = 0; r < `C_TILE_M; r++) begin
      for (int c = 0; c < `C_TILE_N; c++) begin
        read_check(r, c);
      end
    end
  endtask

  // ==================================================
  // directed tests
  // ==================================================

  task automatic after_reset();
    logic seen;
    seen = 1'b0;
    if (tile_done !== 1'b0 || cpu_rvalid !== 1'b0) begin
      $display("MISMATCH tile_done/cpu_rvalid: expected 0x0/0x0, got 0x%h/0x%h",
               tile_done, cpu_rvalid);
      errors++;
    end
    // no tile is done, so this request must be ignored
    cpu_en = 1'b1;
    repeat (20) begin
      @(negedge clk);
      seen = seen | cpu_rvalid;
    end
    cpu_en = 1'b0;
    if (seen) begin
      $display("cpu_rvalid answered a request before any tile was done");
      errors++;
    end
  endtask

  // every flag in one cycle
  task automatic full_tile();
    word_t w;
    pulse_start();
    for (int e = 0; e < ELEMS; e++) begin
      w = $urandom;
      c_valid_flat[e] = 1'b1;
      c_out_flat[e*W +: W] = w;
      model[e] = w;
    end
    @(negedge clk);
    c_valid_flat = '0;
    wait_done();
    read_all();
  endtask

  // random order, quiet gaps shorter than the drain gap
  task automatic scattered_tile();
    int order [ELEMS];
    int j;
    int tmp;
    for (int i = 0; i < ELEMS; i++) begin
      order[i] = i;
    end
    for (int i = ELEMS - 1; i > 0; i--) begin
      j = int'($urandom % (i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    pulse_start();
    for (int i = 0; i < ELEMS; i++) begin
      present(order[i], $urandom);
      repeat (int'($urandom % (GAP - 1))) @(negedge clk);
      if (tile_done) begin
        $display("tile_done rose while elements were still arriving");
        errors++;
      end
    end
    wait_done();
    read_all();
  endtask

  task automatic repeat_valid();
    int e;
    e = int'($urandom % ELEMS);
    pulse_start();
    present(e, $urandom);
    repeat (2) @(negedge clk);
    // the later word must win
    present(e, $urandom);
    wait_done();
    read_check(e / `C_TILE_N, e % `C_TILE_N);
  endtask

  // every third element rewritten, the rest keep the old words
  task automatic new_tile();
    pulse_start();
    if (tile_done !== 1'b0) begin
      $display("MISMATCH tile_done after start: expected 0x0, got 0x%h", tile_done);
      errors++;
    end
    for (int e = 0; e < ELEMS; e += 3) begin
      present(e, $urandom);
    end
    wait_done();
    read_all();
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    void'($urandom(87278));
    errors       = 0;
    clk          = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    flush        = 1'b0;
    c_out_flat   = '0;
    c_valid_flat = '0;
    cpu_en       = 1'b0;
    cpu_row      = '0;
    cpu_col      = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    after_reset();
    full_tile();
    scattered_tile();
    repeat_valid();
    new_tile();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
